// ==== hdl/exec_pkg.sv ====
package exec_pkg;

  localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
  localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

  typedef enum logic [2:0] {
    INST_NOP,
    INST_RR,
    INST_RI,
    INST_LUI,
    INST_AUIPC,
    INST_JAL,
    INST_JALR,
    INST_CSRR
  } inst_type_e;

  typedef enum logic [3:0] {
    ALU_OP_NOP,
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_XOR,
    ALU_OP_OR,
    ALU_OP_AND,
    ALU_OP_SLL,
    ALU_OP_SRL,
    ALU_OP_SRA,
    ALU_OP_SLT,
    ALU_OP_SLTU,
    ALU_OP_LUI,
    ALU_OP_AUIPC,
    ALU_OP_JUMP,
    ALU_OP_CSRR
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // The J immediate is scattered over the upper 20 bits of the word.
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
    j_fmt_t j;
  } inst_word_u;

  typedef struct packed {
    inst_type_e  inst_type;
    alu_op_e     alu_op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [11:0] csr_addr;
  } decoded_t;

  typedef struct packed {
    logic        valid;
    inst_type_e  inst_type;
    alu_op_e     alu_op;
    logic [4:0]  rd;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] csr_rdata;
  } issue_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] pc;
    logic [31:0] data;
    logic        wr;
  } result_t;

endpackage

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder import exec_pkg::*; (
  input  inst_word_u inst_i,
  output decoded_t   decoded_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [31:0] imm_i_ext;
  logic [31:0] imm_u_ext;
  logic [31:0] imm_j_ext;
  logic        f7_zero;
  logic        f7_alt;

  assign imm_i_ext = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
  assign imm_u_ext = {inst_i.u.imm, 12'h000};
  assign imm_j_ext = {{12{inst_i.j.imm20}}, inst_i.j.imm19_12, inst_i.j.imm11,
                      inst_i.j.imm10_1, 1'b0};

  assign f7_zero = (inst_i.r.funct7 == 7'b0000000);
  assign f7_alt  = (inst_i.r.funct7 == 7'b0100000);

  always_comb begin
    decoded_o           = '0;
    decoded_o.rd        = inst_i.r.rd;
    decoded_o.rs1       = inst_i.r.rs1;
    decoded_o.rs2       = inst_i.r.rs2;
    decoded_o.inst_type = INST_NOP;
    decoded_o.alu_op    = ALU_OP_NOP;
    case (inst_i.r.opcode)
      OPC_OP: begin
        decoded_o.inst_type = INST_RR;
        case (inst_i.r.funct3)
          3'b000: decoded_o.alu_op = f7_alt ? ALU_OP_SUB : ALU_OP_ADD;
          3'b001: decoded_o.alu_op = ALU_OP_SLL;
          3'b010: decoded_o.alu_op = ALU_OP_SLT;
          3'b011: decoded_o.alu_op = ALU_OP_SLTU;
          3'b100: decoded_o.alu_op = ALU_OP_XOR;
          3'b101: decoded_o.alu_op = f7_alt ? ALU_OP_SRA : ALU_OP_SRL;
          3'b110: decoded_o.alu_op = ALU_OP_OR;
          default: decoded_o.alu_op = ALU_OP_AND;
        endcase
        // Only SUB and SRA may use the alternate funct7.
        if (!(f7_zero || (f7_alt && (inst_i.r.funct3 == 3'b000 ||
                                     inst_i.r.funct3 == 3'b101)))) begin
          decoded_o.inst_type = INST_NOP;
          decoded_o.alu_op    = ALU_OP_NOP;
        end
      end
      OPC_OP_IMM: begin
        decoded_o.inst_type = INST_RI;
        decoded_o.imm       = imm_i_ext;
        case (inst_i.i.funct3)
          3'b000: decoded_o.alu_op = ALU_OP_ADD;
          3'b001: decoded_o.alu_op = f7_zero ? ALU_OP_SLL : ALU_OP_NOP;
          3'b010: decoded_o.alu_op = ALU_OP_SLT;
          3'b011: decoded_o.alu_op = ALU_OP_SLTU;
          3'b100: decoded_o.alu_op = ALU_OP_XOR;
          3'b101: decoded_o.alu_op = f7_alt ? ALU_OP_SRA :
                                     f7_zero ? ALU_OP_SRL : ALU_OP_NOP;
          3'b110: decoded_o.alu_op = ALU_OP_OR;
          default: decoded_o.alu_op = ALU_OP_AND;
        endcase
        if (decoded_o.alu_op == ALU_OP_NOP) begin
          decoded_o.inst_type = INST_NOP;
        end
      end
      OPC_LUI: begin
        decoded_o.inst_type = INST_LUI;
        decoded_o.alu_op    = ALU_OP_LUI;
        decoded_o.imm       = imm_u_ext;
      end
      OPC_AUIPC: begin
        decoded_o.inst_type = INST_AUIPC;
        decoded_o.alu_op    = ALU_OP_AUIPC;
        decoded_o.imm       = imm_u_ext;
      end
      OPC_JAL: begin
        decoded_o.inst_type = INST_JAL;
        decoded_o.alu_op    = ALU_OP_JUMP;
        decoded_o.imm       = imm_j_ext;
      end
      OPC_JALR: begin
        if (inst_i.i.funct3 == 3'b000) begin
          decoded_o.inst_type = INST_JALR;
          decoded_o.alu_op    = ALU_OP_JUMP;
          decoded_o.imm       = imm_i_ext;
        end
      end
      OPC_SYSTEM: begin
        // Read-only CSRRS of the retired-instruction counter.
        if (inst_i.i.funct3 == 3'b010 && inst_i.i.rs1 == 5'd0 &&
            (inst_i.i.imm == CSR_MINSTRET || inst_i.i.imm == CSR_MINSTRETH)) begin
          decoded_o.inst_type = INST_CSRR;
          decoded_o.alu_op    = ALU_OP_CSRR;
          decoded_o.csr_addr  = inst_i.i.imm;
        end
      end
      default: begin
        decoded_o.inst_type = INST_NOP;
        decoded_o.alu_op    = ALU_OP_NOP;
      end
    endcase
  end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [4:0]  raddr1_i,
  input  logic [4:0]  raddr2_i,
  output logic [31:0] rdata1_o,
  output logic [31:0] rdata2_o,
  input  logic        wr_en_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);

  localparam int IDX_W = $clog2(NUM_REGS);

  logic [31:0]      regs_q [NUM_REGS];
  logic [IDX_W-1:0] ridx1;
  logic [IDX_W-1:0] ridx2;
  logic [IDX_W-1:0] widx;

  // A smaller register file simply drops the upper index bits.
  assign ridx1 = raddr1_i[IDX_W-1:0];
  assign ridx2 = raddr2_i[IDX_W-1:0];
  assign widx  = waddr_i[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && widx != '0) begin
      regs_q[widx] <= wdata_i;
    end
  end

  assign rdata1_o = (ridx1 == '0) ? 32'h0000_0000 : regs_q[ridx1];
  assign rdata2_o = (ridx2 == '0) ? 32'h0000_0000 : regs_q[ridx2];

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/10ps

module csr_file import exec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        retire_i,
  input  logic [11:0] csr_addr_i,
  output logic [31:0] csr_rdata_o
);

  logic [63:0] minstret_q;

  // Counts every retired instruction, NOPs included.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      minstret_q <= '0;
    end else if (retire_i) begin
      minstret_q <= minstret_q + 64'd1;
    end
  end

  always_comb begin
    case (csr_addr_i)
      CSR_MINSTRET:  csr_rdata_o = minstret_q[31:0];
      CSR_MINSTRETH: csr_rdata_o = minstret_q[63:32];
      default:       csr_rdata_o = 32'h0000_0000;
    endcase
  end

endmodule

// ==== hdl/issue_stage.sv ====
`timescale 1ns/10ps

module issue_stage import exec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        inst_valid_i,
  input  inst_word_u  inst_i,
  input  logic [31:0] pc_i,
  output logic [4:0]  rs1_o,
  output logic [4:0]  rs2_o,
  input  logic [31:0] rdata1_i,
  input  logic [31:0] rdata2_i,
  output logic [11:0] csr_addr_o,
  input  logic [31:0] csr_rdata_i,
  input  logic        fwd_valid_i,
  input  result_t     fwd_i,
  output issue_t      issue_o
);

  decoded_t    dec;
  logic        fwd_hit1;
  logic        fwd_hit2;
  logic        fwd_ok;
  logic [31:0] src1;
  logic [31:0] src2;
  issue_t      issue_q;

  inst_decoder i_inst_decoder (
    .inst_i    (inst_i),
    .decoded_o (dec)
  );

  assign rs1_o      = dec.rs1;
  assign rs2_o      = dec.rs2;
  assign csr_addr_o = dec.csr_addr;

  // The instruction in the ALU writes back at the same edge that captures
  // this record, so its result must bypass the register file.
  assign fwd_ok   = fwd_valid_i && fwd_i.wr && (fwd_i.rd != 5'd0);
  assign fwd_hit1 = fwd_ok && (fwd_i.rd == dec.rs1);
  assign fwd_hit2 = fwd_ok && (fwd_i.rd == dec.rs2);

  assign src1 = fwd_hit1 ? fwd_i.data : rdata1_i;
  assign src2 = fwd_hit2 ? fwd_i.data : rdata2_i;

  always_ff @(posedge clk_i) begin
    issue_q.inst_type <= dec.inst_type;
    issue_q.alu_op    <= dec.alu_op;
    issue_q.rd        <= dec.rd;
    issue_q.pc        <= pc_i;
    issue_q.imm       <= dec.imm;
    issue_q.rdata1    <= src1;
    issue_q.rdata2    <= src2;
    issue_q.csr_rdata <= csr_rdata_i;
    if (rst_i) begin
      issue_q.valid <= 1'b0;
    end else begin
      issue_q.valid <= inst_valid_i;
    end
  end

  assign issue_o = issue_q;

endmodule

// ==== hdl/alu_stage.sv ====
`timescale 1ns/10ps

module alu_stage import exec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  issue_t      issue_i,
  output logic        fwd_valid_o,
  output result_t     fwd_o,
  output logic        wr_en_o,
  output logic [4:0]  waddr_o,
  output logic [31:0] wdata_o,
  output logic        retire_o,
  output logic        result_valid_o,
  output result_t     result_o
);

  logic        is_nop;
  logic [31:0] operand1;
  logic [31:0] operand2;
  logic [31:0] alu_result;
  logic        wr_en;
  result_t     result_d;
  result_t     result_q;
  logic        result_valid_q;

  assign is_nop = (issue_i.inst_type == INST_NOP) || (issue_i.alu_op == ALU_OP_NOP);

  always_comb begin
    operand1 = 32'h0000_0000;
    operand2 = 32'h0000_0000;
    if (!is_nop) begin
      case (issue_i.inst_type)
        INST_RR: begin
          operand1 = issue_i.rdata1;
          operand2 = issue_i.rdata2;
        end
        INST_RI: begin
          operand1 = issue_i.rdata1;
          operand2 = issue_i.imm;
        end
        INST_LUI:   operand2 = issue_i.imm;
        INST_AUIPC: begin
          operand1 = issue_i.pc;
          operand2 = issue_i.imm;
        end
        INST_JAL:   operand1 = issue_i.pc;
        INST_JALR:  operand1 = issue_i.pc;
        INST_CSRR:  operand1 = issue_i.csr_rdata;
        default: begin
          operand1 = 32'h0000_0000;
          operand2 = 32'h0000_0000;
        end
      endcase
    end
  end

  always_comb begin
    case (issue_i.alu_op)
      ALU_OP_ADD:   alu_result = operand1 + operand2;
      ALU_OP_SUB:   alu_result = operand1 - operand2;
      ALU_OP_XOR:   alu_result = operand1 ^ operand2;
      ALU_OP_OR:    alu_result = operand1 | operand2;
      ALU_OP_AND:   alu_result = operand1 & operand2;
      ALU_OP_SLL:   alu_result = operand1 << operand2[4:0];
      ALU_OP_SRL:   alu_result = operand1 >> operand2[4:0];
      ALU_OP_SRA:   alu_result = $signed(operand1) >>> operand2[4:0];
      ALU_OP_SLT:   alu_result = {31'b0, $signed(operand1) < $signed(operand2)};
      ALU_OP_SLTU:  alu_result = {31'b0, operand1 < operand2};
      ALU_OP_LUI:   alu_result = operand1 + operand2;
      ALU_OP_AUIPC: alu_result = operand1 + operand2;
      ALU_OP_JUMP:  alu_result = operand1 + 32'h4;
      ALU_OP_CSRR:  alu_result = operand1;
      default:      alu_result = 32'h0000_0000;
    endcase
    if (is_nop) begin
      alu_result = 32'h0000_0000;
    end
  end

  assign wr_en = issue_i.valid && !is_nop && (issue_i.rd != 5'd0);

  // The destination is reported only for instructions that really write.
  assign result_d.rd   = wr_en ? issue_i.rd : 5'd0;
  assign result_d.pc   = issue_i.pc;
  assign result_d.data = alu_result;
  assign result_d.wr   = wr_en;

  assign fwd_valid_o = issue_i.valid;
  assign fwd_o       = result_d;
  assign wr_en_o     = wr_en;
  assign waddr_o     = issue_i.rd;
  assign wdata_o     = alu_result;
  assign retire_o    = issue_i.valid;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_valid_q <= 1'b0;
      result_q       <= '0;
    end else begin
      result_valid_q <= issue_i.valid;
      result_q       <= result_d;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

// ==== hdl/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit import exec_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        inst_valid_i,
  input  logic [31:0] inst_i,
  input  logic [31:0] pc_i,
  output logic        result_valid_o,
  output result_t     result_o
);

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [11:0] csr_addr;
  logic [31:0] csr_rdata;
  logic        fwd_valid;
  result_t     fwd;
  issue_t      issue;
  logic        wr_en;
  logic [4:0]  waddr;
  logic [31:0] wdata;
  logic        retire;

  issue_stage i_issue_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_word_u'(inst_i)),
    .pc_i         (pc_i),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .csr_addr_o   (csr_addr),
    .csr_rdata_i  (csr_rdata),
    .fwd_valid_i  (fwd_valid),
    .fwd_i        (fwd),
    .issue_o      (issue)
  );

  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) i_reg_file (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wr_en_i  (wr_en),
    .waddr_i  (waddr),
    .wdata_i  (wdata)
  );

  csr_file i_csr_file (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .retire_i    (retire),
    .csr_addr_i  (csr_addr),
    .csr_rdata_o (csr_rdata)
  );

  alu_stage i_alu_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue_i        (issue),
    .fwd_valid_o    (fwd_valid),
    .fwd_o          (fwd),
    .wr_en_o        (wr_en),
    .waddr_o        (waddr),
    .wdata_o        (wdata),
    .retire_o       (retire),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

// ==== test/exec_unit_sva.sv ====
`timescale 1ns/10ps

module exec_unit_sva import exec_pkg::*; (
  input logic    clk_i,
  input logic    rst_i,
  input logic    inst_valid_i,
  input logic    result_valid_o,
  input result_t result_o
);

  int unsigned fail_count = 0;

  // Every accepted instruction comes out exactly two cycles later.
  property p_fixed_latency;
    @(posedge clk_i) disable iff (rst_i)
      (!$past(rst_i, 1) && !$past(rst_i, 2)) |-> (result_valid_o == $past(inst_valid_i, 2));
  endproperty

  property p_quiet_after_reset;
    @(posedge clk_i) rst_i |=> !result_valid_o;
  endproperty

  property p_rd_zero_without_write;
    @(posedge clk_i) disable iff (rst_i)
      !result_o.wr |-> (result_o.rd == 5'd0);
  endproperty

  a_fixed_latency: assert property (p_fixed_latency)
  else begin
    $error("result_valid_o does not follow inst_valid_i by two cycles");
    fail_count++;
  end

  a_quiet_after_reset: assert property (p_quiet_after_reset)
  else begin
    $error("result_valid_o high in the cycle after reset");
    fail_count++;
  end

  a_rd_zero_without_write: assert property (p_rd_zero_without_write)
  else begin
    $error("result_o.rd nonzero while the write flag is low");
    fail_count++;
  end

endmodule

bind exec_unit exec_unit_sva i_exec_unit_sva (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .inst_valid_i   (inst_valid_i),
  .result_valid_o (result_valid_o),
  .result_o       (result_o)
);

// ==== test/tb_exec_unit.sv ====
`timescale 1ns/10ps

module tb_exec_unit import exec_pkg::*; ();

  typedef enum int {
    K_ADD, K_SUB, K_XOR, K_OR, K_AND, K_SLT, K_SLTU, K_SLL, K_SRL, K_SRA
  } kind_e;

  typedef struct packed {
    logic [2:0]  test;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [3:0]  gap;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        wr;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        result_valid;
  result_t     result;

  entry_t      tbl[$];
  entry_t      expect_q[$];
  entry_t      exp_e;
  logic        table_built = 1'b0;
  logic [31:0] lfsr = 32'h9e8d_8341;
  logic [31:0] model_regs [32];
  int unsigned issue_cycles[$];
  int unsigned cycle_now;
  logic [31:0] pc_next;
  logic [2:0]  cur_test;
  int          errors = 0;
  int          checks = 0;
  int          test_errors [6] = '{0, 0, 0, 0, 0, 0};
  int          test_checks [6] = '{0, 0, 0, 0, 0, 0};
  string       test_names [6] = '{"alu_rr_ri", "shifts", "upper_jump", "forwarding",
                                  "illegal_op", "csr_minstret"};

  exec_unit #(
    .NUM_REGS (32)
  ) i_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .inst_valid_i   (inst_valid),
    .inst_i         (inst),
    .pc_i           (pc),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  always #5 clk = ~clk;

  // Taps 32, 22, 2, 1; one step per returned bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < n; b++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [2:0] funct3_of(input kind_e k);
    case (k)
      K_SLL:        return 3'b001;
      K_SLT:        return 3'b010;
      K_SLTU:       return 3'b011;
      K_XOR:        return 3'b100;
      K_SRL, K_SRA: return 3'b101;
      K_OR:         return 3'b110;
      K_AND:        return 3'b111;
      default:      return 3'b000;
    endcase
  endfunction

  function automatic logic [6:0] funct7_of(input kind_e k);
    return (k == K_SUB || k == K_SRA) ? 7'b0100000 : 7'b0000000;
  endfunction

  function automatic logic [31:0] ref_alu(input kind_e k, input logic [31:0] a,
                                          input logic [31:0] b);
    case (k)
      K_ADD:   return a + b;
      K_SUB:   return a - b;
      K_XOR:   return a ^ b;
      K_OR:    return a | b;
      K_AND:   return a & b;
      K_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      K_SLL:   return a << b[4:0];
      K_SRL:   return a >> b[4:0];
      default: return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
    endcase
  endfunction

  task automatic start_group(input logic [2:0] id);
    cur_test = id;
    // Groups are separated by a drain, so everything before has retired.
    cycle_now += 100;
  endtask

  task automatic add_entry(input logic [31:0] word, input int gap, input logic [4:0] rd,
                           input logic [31:0] data);
    entry_t e;
    cycle_now += 1 + gap;
    issue_cycles.push_back(cycle_now);
    e.test = cur_test;
    e.inst = word;
    e.pc   = pc_next;
    e.gap  = 4'(gap);
    e.rd   = rd;
    e.data = data;
    e.wr   = (rd != 5'd0);
    if (rd != 5'd0) begin
      model_regs[rd] = data;
    end
    tbl.push_back(e);
    pc_next += 32'd4;
  endtask

  task automatic add_reg_op(input kind_e k, input logic [4:0] rd, rs1, rs2, input int gap);
    add_entry({funct7_of(k), rs2, rs1, funct3_of(k), rd, 7'b0110011}, gap, rd,
              ref_alu(k, model_regs[rs1], model_regs[rs2]));
  endtask

  task automatic add_imm_op(input kind_e k, input logic [4:0] rd, rs1, input logic [11:0] imm,
                            input int gap);
    logic [11:0] field;
    field = imm;
    if (k == K_SLL || k == K_SRL || k == K_SRA) begin
      field = {funct7_of(k), imm[4:0]};
    end
    add_entry({field, rs1, funct3_of(k), rd, 7'b0010011}, gap, rd,
              ref_alu(k, model_regs[rs1], {{20{field[11]}}, field}));
  endtask

  task automatic add_upper(input logic is_auipc, input logic [4:0] rd, input logic [19:0] imm,
                           input int gap);
    add_entry({imm, rd, is_auipc ? 7'b0010111 : 7'b0110111}, gap, rd,
              {imm, 12'h000} + (is_auipc ? pc_next : 32'h0));
  endtask

  task automatic add_jump(input logic is_jalr, input logic [4:0] rd, rs1,
                          input logic [20:0] imm, input int gap);
    logic [31:0] word;
    if (is_jalr) begin
      word = {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
    end else begin
      word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    end
    add_entry(word, gap, rd, pc_next + 32'd4);
  endtask

  task automatic add_csr_read(input logic [4:0] rd, input logic high, input int gap);
    logic [63:0] count;
    int unsigned at;
    at = cycle_now + 1 + gap;
    count = '0;
    // Only instructions issued two or more cycles earlier have retired.
    foreach (issue_cycles[j]) begin
      if (issue_cycles[j] + 2 <= at) begin
        count++;
      end
    end
    add_entry({high ? 12'hB82 : 12'hB02, 5'd0, 3'b010, rd, 7'b1110011}, gap, rd,
              high ? count[63:32] : count[31:0]);
  endtask

  task automatic add_illegal(input logic [31:0] word, input int gap);
    add_entry(word, gap, 5'd0, 32'h0);
  endtask

  task automatic load_value(input logic [4:0] rd, input logic [31:0] v);
    add_upper(1'b0, rd, v[31:12] + v[11], 0);
    add_imm_op(K_ADD, rd, rd, v[11:0], 0);
  endtask

  task automatic build_table();
    foreach (model_regs[r]) begin
      model_regs[r] = 32'h0;
    end
    cycle_now = 0;
    pc_next = 32'h0000_1000;
    start_group(0);
    repeat (2) begin
      for (int r = 1; r <= 6; r++) begin
        load_value(5'(r), rand_bits(32));
      end
      for (int k = 0; k < 7; k++) begin
        add_reg_op(kind_e'(k), 5'(10 + k), 5'(1 + rand_bits(2)), 5'(3 + rand_bits(2)),
                   rand_bits(2));
        if (kind_e'(k) != K_SUB) begin
          add_imm_op(kind_e'(k), 5'(20 + k), 5'(1 + rand_bits(2)), 12'(rand_bits(12)),
                     rand_bits(2));
        end
      end
    end
    start_group(1);
    load_value(1, rand_bits(32) | 32'h8000_0000);
    load_value(2, rand_bits(32) & 32'h7fff_ffff);
    load_value(3, 32'd31);
    load_value(4, 32'hffff_ffe0);
    load_value(5, rand_bits(32));
    for (int k = 7; k < 10; k++) begin
      add_imm_op(kind_e'(k), 10, 1, 12'd0, 0);
      add_imm_op(kind_e'(k), 11, 1, 12'd31, 0);
      add_imm_op(kind_e'(k), 12, 2, 12'(rand_bits(5)), 1);
      add_reg_op(kind_e'(k), 13, 1, 3, 0);
      add_reg_op(kind_e'(k), 14, 2, 4, 0);
      add_reg_op(kind_e'(k), 15, 1, 5, 0);
    end
    start_group(2);
    pc_next = rand_bits(30) << 2;
    add_upper(1'b0, 5, 20'(rand_bits(20)), 0);
    add_upper(1'b1, 6, 20'(rand_bits(20)), 0);
    add_jump(1'b0, 7, 0, 21'(rand_bits(21)), 1);
    add_jump(1'b1, 8, 5, 21'(rand_bits(12)), 0);
    add_upper(1'b0, 0, 20'(rand_bits(20)), 0);
    add_upper(1'b1, 0, 20'(rand_bits(20)), 0);
    add_jump(1'b0, 0, 0, 21'(rand_bits(21)), 0);
    add_jump(1'b1, 0, 6, 21'(rand_bits(12)), 0);
    add_reg_op(K_OR, 9, 0, 0, 0);
    add_imm_op(K_ADD, 10, 0, 12'(rand_bits(12)), 1);
    start_group(3);
    repeat (4) begin
      load_value(1, rand_bits(32));
      add_imm_op(K_ADD, 1, 1, 12'(rand_bits(12)), 0);
      add_reg_op(K_ADD, 2, 1, 1, 0);
      add_reg_op(K_SUB, 3, 2, 1, 0);
      add_imm_op(K_XOR, 4, 3, 12'(rand_bits(12)), 1);
      add_reg_op(K_AND, 5, 4, 3, 0);
      add_reg_op(K_OR, 1, 5, 2, 0);
    end
    start_group(4);
    add_illegal({25'(rand_bits(25)), 7'b0000011}, 0);
    add_illegal({25'(rand_bits(25)), 7'b0100011}, 0);
    add_illegal({7'b0000001, 18'(rand_bits(18)), 7'b0110011}, 0);
    add_illegal({12'hB02, 5'd0, 3'b001, 5'd3, 7'b1110011}, 1);
    add_illegal({25'(rand_bits(25)), 7'b1100011}, 0);
    add_reg_op(K_ADD, 6, 4, 5, 0);
    start_group(5);
    repeat (6) begin
      add_imm_op(K_ADD, 7, 7, 12'(rand_bits(12)), 0);
    end
    add_csr_read(10, 1'b0, 0);
    add_csr_read(11, 1'b1, 0);
    repeat (4) begin
      add_imm_op(K_XOR, 8, 8, 12'(rand_bits(12)), 2);
    end
    add_csr_read(12, 1'b0, 1);
    add_imm_op(K_ADD, 9, 9, 12'(rand_bits(12)), 0);
    add_csr_read(13, 1'b0, 3);
    add_csr_read(14, 1'b1, 2);
  endtask

  task automatic drain_group(input logic [2:0] id);
    @(negedge clk);
    inst_valid = 1'b0;
    while (expect_q.size() != 0) begin
      @(negedge clk);
    end
    $display("%s: %0d results, %0d errors", test_names[id], test_checks[id], test_errors[id]);
  endtask

  task automatic reset_in_flight();
    // An ADDI enters the pipeline and reset arrives while it sits in the ALU stage.
    @(negedge clk);
    inst_valid = 1'b1;
    inst = 32'h0010_0093;
    pc = 32'h0;
    @(negedge clk);
    inst_valid = 1'b0;
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  always @(negedge clk) begin
    if (!rst && result_valid) begin
      assert (expect_q.size() != 0)
      else begin
        errors++;
        $display("Result strobe at %0t with no instruction outstanding", $time);
      end
      if (expect_q.size() != 0) begin
        exp_e = expect_q.pop_front();
        checks++;
        test_checks[exp_e.test]++;
        assert (result.rd == exp_e.rd && result.data == exp_e.data &&
                result.wr == exp_e.wr && result.pc == exp_e.pc)
        else begin
          errors++;
          test_errors[exp_e.test]++;
          $display("[FAIL] %0t: pc %h got rd %0d data %h wr %b, want rd %0d data %h wr %b",
                   $time, exp_e.pc, result.rd, result.data, result.wr,
                   exp_e.rd, exp_e.data, exp_e.wr);
        end
      end
    end
  end

  initial begin : watchdog
    wait (table_built);
    #((tbl.size() * 20 + 10) * 10);
    $display("Watchdog timeout: results stopped arriving from the DUT");
    $display("test failed");
    $finish;
  end

  initial begin
    int total_errors;
    rst = 1'b1;
    inst_valid = 1'b0;
    inst = 32'h0;
    pc = 32'h0;
    build_table();
    table_built = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < tbl.size(); i++) begin
      if (i > 0 && tbl[i].test != tbl[i-1].test) begin
        drain_group(tbl[i-1].test);
      end
      repeat (tbl[i].gap) begin
        @(negedge clk);
        inst_valid = 1'b0;
      end
      @(negedge clk);
      inst_valid = 1'b1;
      inst = tbl[i].inst;
      pc = tbl[i].pc;
      expect_q.push_back(tbl[i]);
    end
    drain_group(tbl[tbl.size()-1].test);
    reset_in_flight();
    total_errors = errors + i_dut.i_exec_unit_sva.fail_count;
    $display("Summary: 6 tests, %0d results checked, %0d errors", checks, total_errors);
    if (total_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hdl/exec_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/issue_stage.sv
hdl/alu_stage.sv
hdl/exec_unit.sv
test/exec_unit_sva.sv
test/tb_exec_unit.sv
